//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mem_subsys
FILELIST  ?= tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- rtl/axi_sram.sv
module axi_sram (
    input  logic                          clk,
    input  logic                          reset,
    // write channels
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [lsu_pkg::ADDR_W-1:0]    awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [lsu_pkg::DATA_W-1:0]    wdata,
    input  logic [lsu_pkg::STRB_W-1:0]    wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output lsu_pkg::resp_e                bresp,
    // read channels
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [lsu_pkg::ADDR_W-1:0]    araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [lsu_pkg::DATA_W-1:0]    rdata,
    output lsu_pkg::resp_e                rresp
);

    logic [lsu_pkg::DATA_W-1:0]     mem [lsu_pkg::SRAM_WORDS];
    logic                           idle;
    logic                           wr_fire;
    logic                           rd_fire;
    logic                           wr_hit;
    logic                           rd_hit;
    logic [lsu_pkg::ADDR_W-1:0]     wr_off;
    logic [lsu_pkg::ADDR_W-1:0]     rd_off;
    logic [lsu_pkg::SRAM_IDX_W-1:0] wr_idx;
    logic [lsu_pkg::SRAM_IDX_W-1:0] rd_idx;

    assign idle = !bvalid && !rvalid;

    // address and data taken together, only once both are offered
    assign awready = idle && awvalid && wvalid;
    assign wready  = awready;
    assign arready = idle;

    assign wr_fire = awvalid && awready;
    assign rd_fire = arvalid && arready;

    // window decode
    assign wr_hit = (awaddr >= lsu_pkg::SRAM_BASE) && (awaddr <= lsu_pkg::SRAM_END);
    assign rd_hit = (araddr >= lsu_pkg::SRAM_BASE) && (araddr <= lsu_pkg::SRAM_END);
    assign wr_off = awaddr - lsu_pkg::SRAM_BASE;
    assign rd_off = araddr - lsu_pkg::SRAM_BASE;
    assign wr_idx = wr_off[lsu_pkg::SRAM_IDX_W+1:2];
    assign rd_idx = rd_off[lsu_pkg::SRAM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // byte-strobed write, out of window writes are dropped
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (wr_hit) begin
                bresp <= lsu_pkg::RESP_OKAY;
                for (int i = 0; i < lsu_pkg::STRB_W; i++) begin
                    if (wstrb[i]) begin
                        mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                bresp <= lsu_pkg::RESP_SLVERR;
            end
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            if (rd_hit) begin
                rdata <= mem[rd_idx];
                rresp <= lsu_pkg::RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= lsu_pkg::RESP_SLVERR;
            end
        end
    end

    a_wstrb_nonzero: assert property (@(posedge clk) disable iff (reset)
        wr_fire |-> (wstrb != '0));

endmodule

//--- rtl/clint.sv
module clint (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd,
    input  logic                          hi,
    output logic [lsu_pkg::DATA_W-1:0]    rdata
);

    logic [63:0] mtime;

    // free running, one tick per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // read port, data valid the cycle after rd
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= hi ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

//--- rtl/lsu.sv
module lsu (
    input  logic                          clk,
    input  logic                          reset,
    // pipeline request
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_write,
    input  logic                          req_signed,
    input  lsu_pkg::size_e                req_size,
    input  logic [lsu_pkg::ADDR_W-1:0]    req_addr,
    input  logic [lsu_pkg::DATA_W-1:0]    req_wdata,
    // pipeline response
    output logic                          resp_valid,
    output logic [lsu_pkg::DATA_W-1:0]    resp_rdata,
    output logic                          resp_err,
    // write channels
    output logic                          awvalid,
    input  logic                          awready,
    output logic [lsu_pkg::ADDR_W-1:0]    awaddr,
    output logic                          wvalid,
    input  logic                          wready,
    output logic [lsu_pkg::DATA_W-1:0]    wdata,
    output logic [lsu_pkg::STRB_W-1:0]    wstrb,
    input  logic                          bvalid,
    output logic                          bready,
    input  lsu_pkg::resp_e                bresp,
    // read channels
    output logic                          arvalid,
    input  logic                          arready,
    output logic [lsu_pkg::ADDR_W-1:0]    araddr,
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [lsu_pkg::DATA_W-1:0]    rdata,
    input  lsu_pkg::resp_e                rresp,
    // timer port
    output logic                          clint_rd,
    output logic                          clint_hi,
    input  logic [lsu_pkg::DATA_W-1:0]    clint_rdata
);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_WAIT, S_DONE} state_e;

    state_e                      state;
    logic                        write_q;
    logic                        signed_q;
    lsu_pkg::size_e              size_q;
    logic [lsu_pkg::ADDR_W-1:0]  addr_q;
    logic [lsu_pkg::DATA_W-1:0]  wdata_q;
    logic [lsu_pkg::DATA_W-1:0]  rdata_q;
    logic                        err_q;
    logic                        aw_done;
    logic                        w_done;
    logic                        is_clint;
    logic                        misaligned;
    logic                        local_done;
    logic                        bus_req;
    logic                        aw_ok;
    logic                        w_ok;
    logic [lsu_pkg::DATA_W-1:0]  bus_rdata;
    logic [lsu_pkg::DATA_W-1:0]  load_data;

    lsu_align u_align (
        .size          (size_q),
        .is_signed     (signed_q),
        .offset        (addr_q[1:0]),
        .wdata         (wdata_q),
        .bus_rdata     (bus_rdata),
        .wstrb         (wstrb),
        .wdata_shifted (wdata),
        .load_data     (load_data),
        .misaligned    (misaligned)
    );

    assign is_clint = (addr_q >= lsu_pkg::CLINT_BASE) && (addr_q <= lsu_pkg::CLINT_END);

    // misaligned and dropped timer writes finish straight out of S_ADDR
    assign local_done = misaligned || (is_clint && write_q);
    assign bus_req    = (state == S_ADDR) && !misaligned && !is_clint;

    assign awvalid = bus_req && write_q && !aw_done;
    assign wvalid  = bus_req && write_q && !w_done;
    assign arvalid = bus_req && !write_q;
    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign bready  = 1'b1;
    assign rready  = 1'b1;

    assign aw_ok = aw_done || awready;
    assign w_ok  = w_done || wready;

    assign clint_rd = (state == S_ADDR) && is_clint && !write_q && !misaligned;
    assign clint_hi = addr_q[lsu_pkg::CLINT_HI_BIT];

    assign req_ready  = (state == S_IDLE);
    assign resp_valid = ((state == S_ADDR) && local_done) || (state == S_DONE);
    assign resp_err   = misaligned || err_q;
    assign bus_rdata  = is_clint ? clint_rdata : rdata_q;
    assign resp_rdata = load_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            err_q   <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state   <= S_ADDR;
                        err_q   <= 1'b0;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                S_ADDR: begin
                    if (local_done) begin
                        state <= S_IDLE;
                    end else if (is_clint) begin
                        // timer data shows up next cycle
                        state <= S_DONE;
                    end else if (write_q) begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                        if (aw_ok && w_ok) begin
                            state <= S_WAIT;
                        end
                    end else if (arready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (write_q && bvalid) begin
                        err_q <= (bresp == lsu_pkg::RESP_SLVERR);
                        state <= S_DONE;
                    end else if (!write_q && rvalid) begin
                        err_q <= (rresp == lsu_pkg::RESP_SLVERR);
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_q  <= req_write;
            signed_q <= req_signed;
            size_q   <= req_size;
            addr_q   <= req_addr;
            wdata_q  <= req_wdata;
        end
        if ((state == S_WAIT) && rvalid) begin
            rdata_q <= rdata;
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid);

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid);

    a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid);

endmodule

//--- rtl/lsu_align.sv
module lsu_align (
    input  lsu_pkg::size_e                size,
    input  logic                          is_signed,
    input  logic [1:0]                    offset,
    input  logic [lsu_pkg::DATA_W-1:0]    wdata,
    input  logic [lsu_pkg::DATA_W-1:0]    bus_rdata,
    output logic [lsu_pkg::STRB_W-1:0]    wstrb,
    output logic [lsu_pkg::DATA_W-1:0]    wdata_shifted,
    output logic [lsu_pkg::DATA_W-1:0]    load_data,
    output logic                          misaligned
);

    logic [lsu_pkg::DATA_W-1:0] lane;
    logic                       sign_bit;

    // store data moves up to its byte lane
    assign wdata_shifted = wdata << {offset, 3'b000};

    // addressed lane brought down to bit 0
    assign lane = bus_rdata >> {offset, 3'b000};

    always_comb begin
        wstrb      = '0;
        load_data  = '0;
        misaligned = 1'b0;
        sign_bit   = 1'b0;
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                wstrb     = 4'b0001 << offset;
                sign_bit  = is_signed & lane[7];
                load_data = {{24{sign_bit}}, lane[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                wstrb      = offset[1] ? 4'b1100 : 4'b0011;
                sign_bit   = is_signed & lane[15];
                load_data  = {{16{sign_bit}}, lane[15:0]};
                misaligned = offset[0];
            end
            lsu_pkg::SIZE_WORD: begin
                wstrb      = 4'b1111;
                load_data  = lane;
                misaligned = (offset != 2'b00);
            end
            default: begin
                // no access, nothing to strobe or return
                wstrb     = '0;
                load_data = '0;
            end
        endcase
    end

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // access size as driven by the pipeline
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } size_e;

    // AXI response codes, only the two we ever return
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // data SRAM window
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam logic [ADDR_W-1:0] SRAM_END = SRAM_BASE + ADDR_W'(SRAM_WORDS * 4 - 1);

    // CLINT window, mtime low word at +0 and high word at +4
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'ha000_0048;
    localparam logic [ADDR_W-1:0] CLINT_END = 32'ha000_004f;

    // address bit that picks the mtime half
    localparam int CLINT_HI_BIT = 2;

endpackage

//--- rtl/mem_subsys_top.sv
module mem_subsys_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_write,
    input  logic                          req_signed,
    input  lsu_pkg::size_e                req_size,
    input  logic [lsu_pkg::ADDR_W-1:0]    req_addr,
    input  logic [lsu_pkg::DATA_W-1:0]    req_wdata,
    output logic                          resp_valid,
    output logic [lsu_pkg::DATA_W-1:0]    resp_rdata,
    output logic                          resp_err
);

    // LSU to SRAM
    logic                        awvalid;
    logic                        awready;
    logic [lsu_pkg::ADDR_W-1:0]  awaddr;
    logic                        wvalid;
    logic                        wready;
    logic [lsu_pkg::DATA_W-1:0]  wdata;
    logic [lsu_pkg::STRB_W-1:0]  wstrb;
    logic                        bvalid;
    logic                        bready;
    lsu_pkg::resp_e              bresp;
    logic                        arvalid;
    logic                        arready;
    logic [lsu_pkg::ADDR_W-1:0]  araddr;
    logic                        rvalid;
    logic                        rready;
    logic [lsu_pkg::DATA_W-1:0]  rdata;
    lsu_pkg::resp_e              rresp;

    // LSU to timer
    logic                        clint_rd;
    logic                        clint_hi;
    logic [lsu_pkg::DATA_W-1:0]  clint_rdata;

    lsu u_lsu (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_signed  (req_signed),
        .req_size    (req_size),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_err    (resp_err),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .clint_rd    (clint_rd),
        .clint_hi    (clint_hi),
        .clint_rdata (clint_rdata)
    );

    axi_sram u_sram (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    clint u_clint (
        .clk   (clk),
        .reset (reset),
        .rd    (clint_rd),
        .hi    (clint_hi),
        .rdata (clint_rdata)
    );

endmodule

//--- tb.f
rtl/lsu_pkg.sv
rtl/lsu_align.sv
rtl/lsu.sv
rtl/clint.sv
rtl/axi_sram.sv
rtl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

//--- tests/tb_mem_subsys.sv
module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int RANDOM_OPS     = 300;

    // one expected response, data only compared on SRAM loads
    typedef struct packed {
        logic                       err;
        logic                       check;
        logic [lsu_pkg::DATA_W-1:0] data;
    } exp_t;

    logic                          clk;
    logic                          reset;
    logic                          req_valid;
    logic                          req_ready;
    logic                          req_write;
    logic                          req_signed;
    lsu_pkg::size_e                req_size;
    logic [lsu_pkg::ADDR_W-1:0]    req_addr;
    logic [lsu_pkg::DATA_W-1:0]    req_wdata;
    logic                          resp_valid;
    logic [lsu_pkg::DATA_W-1:0]    resp_rdata;
    logic                          resp_err;

    logic [lsu_pkg::DATA_W-1:0]    shadow [lsu_pkg::SRAM_WORDS];
    exp_t                          expect_q [$];
    exp_t                          cur_exp;
    logic [31:0]                   lfsr_state = 32'd69682;
    logic [lsu_pkg::DATA_W-1:0]    last_rdata;

    mem_subsys_top UUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_signed (req_signed),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_err   (resp_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // byte-reversed address, so every address bit shows up
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic logic [31:0] sram_addr(input int idx);
        return lsu_pkg::SRAM_BASE + 32'(idx * 4);
    endfunction

    function automatic int sram_index(input logic [31:0] addr);
        return int'((addr - lsu_pkg::SRAM_BASE) >> 2);
    endfunction

    function automatic logic in_sram(input logic [31:0] addr);
        return (addr >= lsu_pkg::SRAM_BASE) &&
               (addr < lsu_pkg::SRAM_BASE + 32'(lsu_pkg::SRAM_WORDS * 4));
    endfunction

    function automatic logic in_clint(input logic [31:0] addr);
        return (addr >= lsu_pkg::CLINT_BASE) && (addr <= lsu_pkg::CLINT_END);
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] word, input int off,
                                                  input lsu_pkg::size_e size, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                b = word[8*off +: 8];
                return sgn ? {{24{b[7]}}, b} : {24'h0, b};
            end
            lsu_pkg::SIZE_HALF: begin
                h = word[8*off +: 16];
                return sgn ? {{16{h[15]}}, h} : {16'h0, h};
            end
            lsu_pkg::SIZE_WORD: return word;
            default: return '0;
        endcase
    endfunction

    function automatic logic expected_err(input logic [31:0] addr, input lsu_pkg::size_e size);
        logic misaligned;
        misaligned = ((size == lsu_pkg::SIZE_HALF) && addr[0]) ||
                     ((size == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00));
        return misaligned || !(in_sram(addr) || in_clint(addr));
    endfunction

    task automatic update_shadow(input logic [31:0] addr, input lsu_pkg::size_e size,
                                 input logic [31:0] data);
        int idx;
        int off;
        idx = sram_index(addr);
        off = int'(addr[1:0]);
        case (size)
            lsu_pkg::SIZE_BYTE: shadow[idx][8*off +: 8] = data[7:0];
            lsu_pkg::SIZE_HALF: shadow[idx][8*off +: 16] = data[15:0];
            default: shadow[idx] = data;
        endcase
    endtask

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        stop_on_error();
    endtask

    task automatic check_data(input logic [lsu_pkg::DATA_W-1:0] actual,
                              input logic [lsu_pkg::DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t resp_rdata expected %h actual %h", $time, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_err(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t resp_err expected %b actual %b", $time, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t req_ready expected %b actual %b", $time, expected, actual);
            stop_on_error();
        end
    endtask

    // one request, from handshake to response
    task automatic do_access(input logic write, input logic sgn, input lsu_pkg::size_e size,
                             input logic [31:0] addr, input logic [31:0] data);
        exp_t e;
        int   waited;
        e.err   = expected_err(addr, size);
        e.check = !write && !e.err && in_sram(addr);
        e.data  = '0;
        if (e.check) begin
            e.data = expected_load(shadow[sram_index(addr)], int'(addr[1:0]), size, sgn);
        end
        expect_q.push_back(e);
        @(posedge clk);
        req_valid  <= 1'b1;
        req_write  <= write;
        req_signed <= sgn;
        req_size   <= size;
        req_addr   <= addr;
        req_wdata  <= data;
        waited = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_timeout("req_ready");
            end
            @(negedge clk);
        end
        // accepted on this edge
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!resp_valid) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_timeout("resp_valid");
            end
            @(negedge clk);
        end
        last_rdata = resp_rdata;
        if (write && !e.err && in_sram(addr)) begin
            update_shadow(addr, size, data);
        end
    endtask

    task automatic verify_all_sram();
        for (int i = 0; i < lsu_pkg::SRAM_WORDS; i++) begin
            do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(i), '0);
        end
    endtask

    // every response against the head of the queue
    always @(negedge clk) begin
        if (!reset && resp_valid) begin
            if (expect_q.size() == 0) begin
                $display("response seen with no request outstanding");
                stop_on_error();
            end else begin
                cur_exp = expect_q.pop_front();
                // a request is still in flight, so the LSU is busy
                check_ready(req_ready, 1'b0);
                check_err(resp_err, cur_exp.err);
                if (cur_exp.check) begin
                    check_data(resp_rdata, cur_exp.data);
                end
            end
        end
    end

    initial begin
        logic [31:0]    addr;
        logic [31:0]    r;
        logic [31:0]    first;
        lsu_pkg::size_e size;
        logic [31:0]    bad_addr [4];
        bad_addr[0] = 32'h0000_1000;
        bad_addr[1] = lsu_pkg::SRAM_BASE + 32'(lsu_pkg::SRAM_WORDS * 4);
        bad_addr[2] = lsu_pkg::CLINT_BASE - 32'd8;
        bad_addr[3] = lsu_pkg::CLINT_END + 32'd1;
        reset      <= 1'b1;
        req_valid  <= 1'b0;
        req_write  <= 1'b0;
        req_signed <= 1'b0;
        req_size   <= lsu_pkg::SIZE_WORD;
        req_addr   <= '0;
        req_wdata  <= '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // known contents in every word
        for (int i = 0; i < lsu_pkg::SRAM_WORDS; i++) begin
            do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(i), fill_pattern(sram_addr(i)));
        end

        do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(16), 32'hdead_beef);
        do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(16), '0);

        // sub-word stores, upper bits of wdata are noise
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_BYTE, sram_addr(32) + 32'd0, {take_bits(24), 8'h81});
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_BYTE, sram_addr(32) + 32'd1, {take_bits(24), 8'h12});
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_BYTE, sram_addr(32) + 32'd2, {take_bits(24), 8'hf3});
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_BYTE, sram_addr(32) + 32'd3, {take_bits(24), 8'h44});
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_HALF, sram_addr(33) + 32'd0, {take_bits(16), 16'h8001});
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_HALF, sram_addr(33) + 32'd2, {take_bits(16), 16'h7ffe});
        for (int w = 32; w < 34; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int sg = 0; sg < 2; sg++) begin
                    addr = sram_addr(w) + 32'(off);
                    do_access(1'b0, sg[0], lsu_pkg::SIZE_BYTE, addr, '0);
                    if (off[0] == 1'b0) begin
                        do_access(1'b0, sg[0], lsu_pkg::SIZE_HALF, addr, '0);
                    end
                    if (off == 0) begin
                        do_access(1'b0, sg[0], lsu_pkg::SIZE_WORD, addr, '0);
                    end
                end
            end
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = take_bits(2);
            case (r[1:0])
                2'd0: size = lsu_pkg::SIZE_BYTE;
                2'd1: size = lsu_pkg::SIZE_HALF;
                default: size = lsu_pkg::SIZE_WORD;
            endcase
            addr = sram_addr(int'(take_bits(8)));
            r = take_bits(2);
            if (size == lsu_pkg::SIZE_BYTE) begin
                addr[1:0] = r[1:0];
            end else if (size == lsu_pkg::SIZE_HALF) begin
                addr[1:0] = {r[0], 1'b0};
            end
            // bit 0 picks store, bit 1 picks signed
            r = take_bits(2);
            do_access(r[0], r[1], size, addr, take_bits(32));
        end

        // misaligned, memory must stay as it was
        for (int off = 1; off < 4; off++) begin
            addr = sram_addr(40) + 32'(off);
            if (off[0]) begin
                do_access(1'b1, 1'b0, lsu_pkg::SIZE_HALF, addr, 32'hffff_ffff);
                do_access(1'b0, 1'b1, lsu_pkg::SIZE_HALF, addr, '0);
            end
            do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, addr, 32'hffff_ffff);
            do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, addr, '0);
            do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(40), '0);
        end

        // nothing mapped here
        for (int i = 0; i < 4; i++) begin
            do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, bad_addr[i], 32'h5555_aaaa);
            do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, bad_addr[i], '0);
        end
        verify_all_sram();

        // mtime keeps counting between reads
        do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, '0);
        first = last_rdata;
        for (int i = 0; i < 10; i++) begin
            do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, sram_addr(i), '0);
        end
        do_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, '0);
        if ((last_rdata > first) !== 1'b1) begin
            $display("mtime did not advance, first read %h, second read %h", first, last_rdata);
            stop_on_error();
        end
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, 32'h1234_5678);
        do_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE + 32'd4, 32'h9abc_def0);
        verify_all_sram();

        @(posedge clk);
        if (expect_q.size() != 0) begin
            $display("%0d expected responses never arrived", expect_q.size());
            stop_on_error();
        end
        $display("No errors");
        $finish;
    end

endmodule
